// File: Makefile
TOP := tb_axis_qmul

all: run

run:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o sim
	./obj_dir/sim | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

lint:
	verilator --lint-only -Wall +incdir+. qmul_pkg.sv operand_collector.sv \
	  q_multiplier.sv result_egress.sv axis_qmul_top.sv --top-module axis_qmul_top

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean

// File: axis_qmul_props.sv
`timescale 1ns/100ps
`default_nettype none

module axis_qmul_props (
  input logic clk,
  input logic rst_n,
  input logic ing_tvalid,
  input logic ing_tready,
  input logic ing_tlast,
  input logic egr_tvalid
);

  // tlast beat taken on this edge
  logic last_acc;
  assign last_acc = ing_tvalid && ing_tready && ing_tlast;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake and latency
  ////////////////////////////////////////////////////////////////////////////

  // Ingress pauses for the hand-over cycle
  ready_drop: assert property (@(posedge clk) disable iff (!rst_n)
    last_acc |=> !ing_tready)
    else $error("ing_tready high in the cycle after a tlast beat");

  // Beat registered on the third edge after acceptance, seen one edge later
  egress_on_time: assert property (@(posedge clk) disable iff (!rst_n)
    $past(last_acc, 4) |-> egr_tvalid)
    else $error("egr_tvalid missing three cycles after a tlast beat");

  // Low just before, so it is a rise
  egress_not_early: assert property (@(posedge clk) disable iff (!rst_n)
    $past(last_acc, 3) |-> !egr_tvalid)
    else $error("egr_tvalid high one cycle early");

  // No beat without a tlast beat behind it
  egress_has_source: assert property (@(posedge clk) disable iff (!rst_n)
    egr_tvalid |-> $past(last_acc, 4))
    else $error("egr_tvalid without a matching tlast beat");

  // One beat per packet
  egress_single: assert property (@(posedge clk) disable iff (!rst_n)
    egr_tvalid |=> !egr_tvalid)
    else $error("egr_tvalid high in two consecutive cycles");

  known_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
    !$isunknown({egr_tvalid, ing_tready}))
    else $error("egr_tvalid or ing_tready unknown");

endmodule

bind axis_qmul_top axis_qmul_props u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .ing_tvalid (ing_tvalid),
  .ing_tready (ing_tready),
  .ing_tlast  (ing_tlast),
  .egr_tvalid (egr_tvalid)
);

`default_nettype wire

// File: axis_qmul_top.sv
`include "mul_cfg.svh"

`timescale 1ns/100ps
`default_nettype none

module axis_qmul_top (
  input  logic                   clk,
  input  logic                   rst_n,

  // AXI4-Stream ingress
  input  logic                   ing_tvalid,
  output logic                   ing_tready,
  input  logic [`MUL_DATA_W-1:0] ing_tdata,
  input  logic                   ing_tlast,
  input  qmul_pkg::stream_id_t   ing_tid,

  // AXI4-Stream egress
  output logic                   egr_tvalid,
  output logic [`MUL_DATA_W-1:0] egr_tdata,
  output qmul_pkg::stream_id_t   egr_tid,
  output logic                   egr_tuser,

  output logic [`MUL_CNT_W-1:0]  ovf_count
);

  import qmul_pkg::*;

  // Collector to core
  logic       op_valid;
  q_word_t    op_a;
  q_word_t    op_b;
  stream_id_t op_id;

  // Core to egress
  logic       res_valid;
  q_word_t    res_data;
  logic       res_ovf;
  stream_id_t res_id;

  ////////////////////////////////////////////////////////////////////////////
  // Input side
  ////////////////////////////////////////////////////////////////////////////

  operand_collector u_collector (
    .clk        (clk),
    .rst_n      (rst_n),
    .ing_tvalid (ing_tvalid),
    .ing_tready (ing_tready),
    .ing_tdata  (ing_tdata),
    .ing_tlast  (ing_tlast),
    .ing_tid    (ing_tid),
    .op_valid   (op_valid),
    .op_a       (op_a),
    .op_b       (op_b),
    .op_id      (op_id)
  );

  // Two-stage fixed-point core
  q_multiplier u_mult (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_valid  (op_valid),
    .op_a      (op_a),
    .op_b      (op_b),
    .op_id     (op_id),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_ovf   (res_ovf),
    .res_id    (res_id)
  );

  // Output side
  result_egress u_egress (
    .clk        (clk),
    .rst_n      (rst_n),
    .res_valid  (res_valid),
    .res_data   (res_data),
    .res_ovf    (res_ovf),
    .res_id     (res_id),
    .egr_tvalid (egr_tvalid),
    .egr_tdata  (egr_tdata),
    .egr_tid    (egr_tid),
    .egr_tuser  (egr_tuser),
    .ovf_count  (ovf_count)
  );

endmodule

`default_nettype wire

// File: mul_cfg.svh
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

`default_nettype none

// Stream side widths
`define MUL_DATA_W 32
`define MUL_ID_W   4

// Fixed-point format, N total bits with Q fractional
`define MUL_N_BITS 16
`define MUL_Q_BITS 8

// Saturating overflow counter
`define MUL_CNT_W  16

`default_nettype wire

`endif

// File: operand_collector.sv
`include "mul_cfg.svh"

`timescale 1ns/100ps
`default_nettype none

module operand_collector (
  input  logic                   clk,
  input  logic                   rst_n,

  // AXI4-Stream ingress
  input  logic                   ing_tvalid,
  output logic                   ing_tready,
  input  logic [`MUL_DATA_W-1:0] ing_tdata,
  input  logic                   ing_tlast,
  input  qmul_pkg::stream_id_t   ing_tid,

  // Operands towards the core
  output logic                   op_valid,
  output qmul_pkg::q_word_t      op_a,
  output qmul_pkg::q_word_t      op_b,
  output qmul_pkg::stream_id_t   op_id
);

  import qmul_pkg::*;

  localparam int N = `MUL_N_BITS;

  // Beat transfer on this edge
  logic    beat_acc;
  // Low N bits of tdata
  q_word_t beat_word;

  assign beat_acc  = ing_tvalid && ing_tready;
  assign beat_word = q_word_t'(ing_tdata[N-1:0]);

  ////////////////////////////////////////////////////////////////////////////
  // Operand capture
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ing_tready <= 1'b1;
      op_valid   <= 1'b0;
      op_a       <= '0;
      op_b       <= '0;
      op_id      <= '0;
    end else begin
      // Strobe lasts a single cycle
      op_valid   <= 1'b0;
      // Ready comes back after the hand-over cycle
      ing_tready <= 1'b1;

      if (beat_acc) begin
        if (!ing_tlast) begin
          // Multiplicand and its tag
          // Kept across packets until the next non-last beat
          op_a  <= beat_word;
          op_id <= ing_tid;
        end else begin
          // Multiplier beat starts the operation
          op_b       <= beat_word;
          op_valid   <= 1'b1;
          // Hold off ingress while operands are handed over
          ing_tready <= 1'b0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
qmul_pkg.sv
operand_collector.sv
q_multiplier.sv
result_egress.sv
axis_qmul_top.sv
axis_qmul_props.sv
tb_axis_qmul.sv

// File: q_multiplier.sv
`include "mul_cfg.svh"

`timescale 1ns/100ps
`default_nettype none

module q_multiplier (
  input  logic                 clk,
  input  logic                 rst_n,

  // Operands from the collector
  input  logic                 op_valid,
  input  qmul_pkg::q_word_t    op_a,
  input  qmul_pkg::q_word_t    op_b,
  input  qmul_pkg::stream_id_t op_id,

  // Result towards egress
  output logic                 res_valid,
  output qmul_pkg::q_word_t    res_data,
  output logic                 res_ovf,
  output qmul_pkg::stream_id_t res_id
);

  import qmul_pkg::*;

  localparam int N = `MUL_N_BITS;
  localparam int Q = `MUL_Q_BITS;

  // Half an LSB of the result, added before the shift
  localparam q_full_t RND_HALF = q_full_t'(1) <<< (Q - 1);

  // Saturation limits
  localparam q_word_t WORD_MAX = {1'b0, {(N-1){1'b1}}};
  localparam q_word_t WORD_MIN = {1'b1, {(N-1){1'b0}}};

  // Full signed product of the operands
  q_full_t    product;

  // Stage 1 registers
  logic       s1_valid;
  q_full_t    s1_prod;
  stream_id_t s1_id;

  // Stage 2 datapath
  q_full_t    rounded;
  q_full_t    scaled;
  logic [N:0] top_bits;
  logic       fits;
  q_word_t    sat_word;

  ////////////////////////////////////////////////////////////////////////////
  // Stage 1 multiply
  ////////////////////////////////////////////////////////////////////////////

  // Signed operands in a 2N context
  assign product = op_a * op_b;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      s1_prod  <= '0;
      s1_id    <= '0;
    end else begin
      s1_valid <= op_valid;
      if (op_valid) begin
        s1_prod <= product;
        s1_id   <= op_id;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage 2 round, scale and saturate
  ////////////////////////////////////////////////////////////////////////////

  // Round half up at bit Q
  assign rounded  = s1_prod + RND_HALF;
  // Arithmetic shift keeps the sign
  assign scaled   = rounded >>> Q;

  // Result fits when the bits above the sign bit copy it
  assign top_bits = scaled[2*N-1:N-1];
  assign fits     = (top_bits == '0) || (top_bits == '1);

  // Nearest limit by sign of the full product
  assign sat_word = s1_prod[2*N-1] ? WORD_MIN : WORD_MAX;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid <= 1'b0;
      res_data  <= '0;
      res_ovf   <= 1'b0;
      res_id    <= '0;
    end else begin
      res_valid <= s1_valid;
      if (s1_valid) begin
        res_data <= fits ? q_word_t'(scaled[N-1:0]) : sat_word;
        res_ovf  <= !fits;
        res_id   <= s1_id;
      end
    end
  end

endmodule

`default_nettype wire

// File: qmul_pkg.sv
`include "mul_cfg.svh"

`default_nettype none

package qmul_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Fixed-point words
  //////////////////////////////////////////////////////////////////////////

  // Operand and result word, N bits with Q fractional
  typedef logic signed [`MUL_N_BITS-1:0] q_word_t;

  // Full product before rounding
  // Twice the word width, never overflows for N-bit operands
  typedef logic signed [2*`MUL_N_BITS-1:0] q_full_t;

  //////////////////////////////////////////////////////////////////////////
  // Stream tags
  //////////////////////////////////////////////////////////////////////////

  // tid carried from ingress to egress
  typedef logic [`MUL_ID_W-1:0] stream_id_t;

endpackage

`default_nettype wire

// File: result_egress.sv
`include "mul_cfg.svh"

`timescale 1ns/100ps
`default_nettype none

module result_egress (
  input  logic                   clk,
  input  logic                   rst_n,

  // Result from the core
  input  logic                   res_valid,
  input  qmul_pkg::q_word_t      res_data,
  input  logic                   res_ovf,
  input  qmul_pkg::stream_id_t   res_id,

  // Egress beat, no back-pressure
  output logic                   egr_tvalid,
  output logic [`MUL_DATA_W-1:0] egr_tdata,
  output qmul_pkg::stream_id_t   egr_tid,
  output logic                   egr_tuser,

  output logic [`MUL_CNT_W-1:0]  ovf_count
);

  import qmul_pkg::*;

  localparam int N      = `MUL_N_BITS;
  localparam int DATA_W = `MUL_DATA_W;

  // Result sign-extended to the stream width
  logic [DATA_W-1:0] ext_data;
  // Counter stops at all ones
  logic              cnt_full;

  assign ext_data = {{(DATA_W-N){res_data[N-1]}}, res_data};
  assign cnt_full = &ovf_count;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      egr_tvalid <= 1'b0;
      egr_tdata  <= '0;
      egr_tid    <= '0;
      egr_tuser  <= 1'b0;
      ovf_count  <= '0;
    end else begin
      egr_tvalid <= res_valid;
      // Beat fields hold between strobes
      if (res_valid) begin
        egr_tdata <= ext_data;
        egr_tid   <= res_id;
        egr_tuser <= res_ovf;
      end
      if (res_valid && res_ovf && !cnt_full) begin
        ovf_count <= ovf_count + `MUL_CNT_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_axis_qmul.sv
`include "mul_cfg.svh"

`timescale 1ns/100ps
`default_nettype none

module tb_axis_qmul;

  import qmul_pkg::*;

  localparam int N = `MUL_N_BITS;
  localparam int Q = `MUL_Q_BITS;
  localparam int NUM_PKT = 400;
  // Worst packet: 4 beats, one ready-low cycle, 3 idle cycles
  localparam int CYC_LIMIT = NUM_PKT * 8 + 200;
  localparam longint W_MAX = (longint'(1) <<< (N - 1)) - 1;
  localparam longint W_MIN = -(longint'(1) <<< (N - 1));

  logic clk, rst_n, ing_tvalid, ing_tready, ing_tlast, egr_tvalid, egr_tuser;
  logic [`MUL_DATA_W-1:0] ing_tdata, egr_tdata;
  stream_id_t ing_tid, egr_tid;
  logic [`MUL_CNT_W-1:0] ovf_count;

  // Stimulus and model state
  logic [31:0] rng_state;
  q_word_t mdl_a;
  stream_id_t mdl_id;
  int mdl_ovf, cyc, err_value, err_other, sat_pos, sat_neg;
  int beats_left, gap_left, pkt_sent;
  // Expected egress beats, oldest first
  int exp_cyc[$];
  logic [31:0] exp_data[$];
  stream_id_t exp_tid[$];
  logic exp_ovf[$];

  axis_qmul_top uut (
    .clk(clk), .rst_n(rst_n),
    .ing_tvalid(ing_tvalid), .ing_tready(ing_tready), .ing_tdata(ing_tdata),
    .ing_tlast(ing_tlast), .ing_tid(ing_tid),
    .egr_tvalid(egr_tvalid), .egr_tdata(egr_tdata), .egr_tid(egr_tid),
    .egr_tuser(egr_tuser), .ovf_count(ovf_count)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Mix of near-limit, full-range and small operands
  function automatic q_word_t draw_operand();
    logic [31:0] r;
    r = next_rand();
    case (r[31:30])
      2'd0: return r[29] ? q_word_t'({8'h7f, r[7:0]}) : q_word_t'({8'h80, r[7:0]});
      2'd1: return q_word_t'(r[15:0]);
      default: return q_word_t'({{4{r[11]}}, r[11:0]});
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail %s: expected 0x%08h, actual 0x%08h (cycle %0d)",
               name, expected, actual, cyc);
      err_value++;
    end
  endtask

  task automatic finish_run();
    $display("Errors: value %0d, other %0d", err_value, err_other);
    if (err_value + err_other == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  endtask

  // Full product, round half up at bit Q, saturate to N signed bits
  task automatic predict(input q_word_t b, input int beat_cyc);
    longint full;
    longint scaled;
    logic ovf;
    full = longint'(mdl_a) * longint'(b);
    scaled = (full + (longint'(1) <<< (Q - 1))) >>> Q;
    ovf = 1'b1;
    if (scaled > W_MAX) begin
      scaled = W_MAX;
      sat_pos++;
    end else if (scaled < W_MIN) begin
      scaled = W_MIN;
      sat_neg++;
    end else begin
      ovf = 1'b0;
    end
    exp_cyc.push_back(beat_cyc);
    exp_data.push_back(scaled[31:0]);
    exp_tid.push_back(mdl_id);
    exp_ovf.push_back(ovf);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor and driver, both on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_outputs(input logic last_before);
    logic [31:0] d;
    stream_id_t t;
    logic o;
    // Ready is low only in the cycle after a tlast beat
    check_value("ing_tready", 32'(!last_before), 32'(ing_tready));
    while (exp_cyc.size() > 0 && exp_cyc[0] < cyc) begin
      $display("Missing egress beat, expected in cycle %0d", exp_cyc[0]);
      err_other++;
      void'(exp_cyc.pop_front());
      d = exp_data.pop_front();
      t = exp_tid.pop_front();
      o = exp_ovf.pop_front();
      if (o) mdl_ovf++;
    end
    if (egr_tvalid === 1'b1) begin
      if (exp_cyc.size() > 0 && exp_cyc[0] == cyc) begin
        void'(exp_cyc.pop_front());
        d = exp_data.pop_front();
        t = exp_tid.pop_front();
        o = exp_ovf.pop_front();
        check_value("egr_tdata", d, egr_tdata);
        check_value("egr_tid", 32'(t), 32'(egr_tid));
        check_value("egr_tuser", 32'(o), 32'(egr_tuser));
        // Counter holds at all ones
        if (o && mdl_ovf < (1 << `MUL_CNT_W) - 1) mdl_ovf++;
        check_value("ovf_count", mdl_ovf, 32'(ovf_count));
      end else begin
        $display("Unexpected egress beat in cycle %0d", cyc);
        err_other++;
      end
    end
  endtask

  task automatic drive_inputs(output logic sent_last);
    logic [31:0] r;
    r = next_rand();
    sent_last = 1'b0;
    ing_tvalid = 1'b0;
    ing_tlast = 1'b0;
    // Junk on idle data lines
    ing_tdata = r;
    ing_tid = stream_id_t'(r[7:4]);
    if (gap_left > 0) begin
      gap_left--;
    end else if (pkt_sent < NUM_PKT && ing_tready) begin
      // First packet after reset is one beat, so it meets the zero multiplicand
      if (beats_left == 0) beats_left = (pkt_sent == 0) ? 1 : int'(r[1:0]) + 1;
      ing_tvalid = 1'b1;
      ing_tdata = {r[31:16], draw_operand()};
      beats_left--;
      if (beats_left == 0) begin
        ing_tlast = 1'b1;
        sent_last = 1'b1;
        // Taken on edge cyc+1, beat visible after edge cyc+4
        predict(q_word_t'(ing_tdata[N-1:0]), cyc + 4);
        pkt_sent++;
        gap_left = r[2] ? 0 : int'(r[9:8]);
      end else begin
        mdl_a = q_word_t'(ing_tdata[N-1:0]);
        mdl_id = ing_tid;
      end
    end
  endtask

  // Edge count, also the run limit
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("Timeout after %0d cycles, results still outstanding", CYC_LIMIT);
      err_other++;
      finish_run();
    end
  end

  initial begin
    logic last_before;
    clk = 1'b0;
    rst_n = 1'b0;
    ing_tvalid = 1'b0;
    ing_tdata = '0;
    ing_tlast = 1'b0;
    ing_tid = '0;
    rng_state = 32'd20;
    mdl_a = '0;
    mdl_id = '0;
    {mdl_ovf, err_value, err_other, sat_pos, sat_neg} = '0;
    {beats_left, gap_left, pkt_sent} = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    // Reset state
    check_value("reset ing_tready", 32'd1, 32'(ing_tready));
    check_value("reset egr_tvalid", 32'd0, 32'(egr_tvalid));
    check_value("reset egr_tdata", 32'd0, egr_tdata);
    check_value("reset egr_tid", 32'd0, 32'(egr_tid));
    check_value("reset ovf_count", 32'd0, 32'(ovf_count));
    last_before = 1'b0;
    while (pkt_sent < NUM_PKT || exp_cyc.size() > 0) begin
      @(negedge clk);
      check_outputs(last_before);
      drive_inputs(last_before);
    end
    // Idle tail catches stray beats
    repeat (6) begin
      @(negedge clk);
      check_outputs(last_before);
      drive_inputs(last_before);
    end
    if (sat_pos == 0 || sat_neg == 0) begin
      $display("Saturation was not reached in both directions");
      err_other++;
    end
    check_value("final ovf_count", mdl_ovf, 32'(ovf_count));
    finish_run();
  end

endmodule

`default_nettype wire
